/* logic/board_io_pkg.sv */
// Shared constants for the memory-mapped I/O block and serial loader
// Imported by every RTL module of the I/O subsystem

package board_io_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////
  localparam int addr_width      = 18;
  localparam int data_width      = 16;
  localparam int io_offset_width = 4;

  // Upper address bits that select the I/O block
  localparam logic [addr_width-io_offset_width-1:0] io_block_base = 14'h0FF;

  ////////////////////////////////////////
  // Register offsets inside the block
  ////////////////////////////////////////
  localparam logic [io_offset_width-1:0] reg_switch      = 4'h0;
  localparam logic [io_offset_width-1:0] reg_inputs      = 4'h1;
  localparam logic [io_offset_width-1:0] reg_mode        = 4'h2;
  localparam logic [io_offset_width-1:0] reg_uart_status = 4'hE;
  localparam logic [io_offset_width-1:0] reg_uart_data   = 4'hF;

  // UART status word layout
  localparam int uart_status_bit_tbe   = 15;
  localparam int uart_status_bit_tse   = 14;
  localparam int uart_status_bit_ferr  = 13;
  localparam int uart_status_bit_oerr  = 12;
  localparam int uart_status_bit_avail = 11;
  localparam int uart_data_avail_bit   = 15;

  // Mode register bits
  localparam int mode_bit_load = 0;
  localparam int mode_bit_run  = 1;

  ////////////////////////////////////////
  // Serial timing and loader hold time
  ////////////////////////////////////////
  localparam int clks_per_bit     = 16;
  localparam int baud_cnt_width   = $clog2(clks_per_bit);
  localparam logic [baud_cnt_width-1:0] baud_last = baud_cnt_width'(clks_per_bit - 1);
  localparam logic [baud_cnt_width-1:0] baud_half = baud_cnt_width'(clks_per_bit / 2 - 1);
  localparam int load_hold_cycles = 8;
  localparam int hold_cnt_width   = $clog2(load_hold_cycles + 1);

endpackage

/* logic/io_decode.sv */
// Address decode for the I/O block, register strobes and registered read data
// Also produces the active-low memory chip enable for all other addresses
`timescale 1ns/1ps

module io_decode
  import board_io_pkg::*;
(
  input  logic                  clk,
  input  logic                  clear,
  input  logic [addr_width-1:0] bus_addr,
  input  logic                  bus_write,
  input  logic                  bus_read,
  input  logic [data_width-1:0] switch_reg,
  input  logic [7:0]            sw,
  input  logic                  button,
  input  logic                  load_mode_bit,
  input  logic                  run_bit,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_avail,
  input  logic                  ferr,
  input  logic                  oerr,
  input  logic                  tbe,
  input  logic                  tse,
  output logic                  wr_switch,
  output logic                  wr_mode,
  output logic                  wr_uart_data,
  output logic                  rd_uart_data,
  output logic                  mem_ce_n,
  output logic [data_width-1:0] bus_rdata
);

  logic                       in_block;
  logic [io_offset_width-1:0] offset;
  logic                       wr_io;
  logic                       rd_io;
  logic [data_width-1:0]      rd_mux;

  assign in_block = (bus_addr[addr_width-1:io_offset_width] == io_block_base);
  assign offset   = bus_addr[io_offset_width-1:0];
  assign wr_io    = bus_write && in_block;
  assign rd_io    = bus_read && in_block;

  // External memory only sees accesses outside the block
  assign mem_ce_n = !((bus_read || bus_write) && !in_block);

  // Per-register strobes
  assign wr_switch    = wr_io && (offset == reg_switch);
  assign wr_mode      = wr_io && (offset == reg_mode);
  assign wr_uart_data = wr_io && (offset == reg_uart_data);
  assign rd_uart_data = rd_io && (offset == reg_uart_data);

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////
  always_comb
  begin
    rd_mux = '0;
    case (offset)
      reg_switch: rd_mux = switch_reg;
      // Button on top, switches in low byte
      reg_inputs: rd_mux = {button, 7'b0, sw};
      reg_mode:
      begin
        rd_mux[mode_bit_load] = load_mode_bit;
        rd_mux[mode_bit_run]  = run_bit;
      end
      reg_uart_status:
      begin
        rd_mux[uart_status_bit_tbe]   = tbe;
        rd_mux[uart_status_bit_tse]   = tse;
        rd_mux[uart_status_bit_ferr]  = ferr;
        rd_mux[uart_status_bit_oerr]  = oerr;
        rd_mux[uart_status_bit_avail] = rx_avail;
      end
      reg_uart_data:
      begin
        // Avail sampled before this read clears it
        rd_mux[7:0]                 = rx_byte;
        rd_mux[uart_data_avail_bit] = rx_avail;
      end
      default: rd_mux = '0;
    endcase
  end

  // Zero unless the previous cycle read the block
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
      bus_rdata <= '0;
    else
      bus_rdata <= rd_io ? rd_mux : '0;
  end

  // Bus master never issues read and write together
  a_no_rw_overlap: assert property (@(posedge clk) disable iff (clear)
    !(bus_read && bus_write));

endmodule

/* logic/panel_regs.sv */
// CPU-writable switch register and mode register
// Mode bits steer the serial loader and the deposit source
`timescale 1ns/1ps

module panel_regs
  import board_io_pkg::*;
(
  input  logic                  clk,
  input  logic                  clear,
  input  logic [data_width-1:0] bus_wdata,
  input  logic                  wr_switch,
  input  logic                  wr_mode,
  output logic [data_width-1:0] switch_reg,
  output logic                  load_mode_bit,
  output logic                  run_bit,
  output logic                  load_mode
);

  ////////////////////////////////////////
  // Switch register
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
      switch_reg <= '0;
    else if (wr_switch)
      switch_reg <= bus_wdata;
  end

  ////////////////////////////////////////
  // Mode register
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
    begin
      load_mode_bit <= 1'b0;
      run_bit       <= 1'b0;
    end
    else if (wr_mode)
    begin
      load_mode_bit <= bus_wdata[mode_bit_load];
      run_bit       <= bus_wdata[mode_bit_run];
    end
  end

  // Loader only runs with the CPU halted
  assign load_mode = load_mode_bit && !run_bit;

endmodule

/* logic/serial_loader.sv */
// Builds a 16-bit word from two received bytes, high byte first
// and holds the deposit level for a fixed number of cycles
`timescale 1ns/1ps

module serial_loader
  import board_io_pkg::*;
(
  input  logic                  clk,
  input  logic                  clear,
  input  logic                  load_mode,
  input  logic                  rx_avail,
  input  logic [7:0]            rx_byte,
  output logic                  take_byte,
  output logic [data_width-1:0] load_word,
  output logic                  load_active
);

  // Set once the high byte is in
  logic                      high_done;
  logic [hold_cnt_width-1:0] hold_cnt;

  // Bytes wait in the UART while a deposit is held
  assign take_byte = load_mode && rx_avail && !load_active;

  ////////////////////////////////////////
  // Byte phase and deposit timing
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
    begin
      high_done   <= 1'b0;
      load_active <= 1'b0;
      hold_cnt    <= '0;
    end
    else if (!load_mode)
    begin
      // Dropping out of load mode abandons a half word
      high_done   <= 1'b0;
      load_active <= 1'b0;
      hold_cnt    <= '0;
    end
    else if (take_byte)
    begin
      high_done <= !high_done;
      if (high_done)
      begin
        load_active <= 1'b1;
        hold_cnt    <= '0;
      end
    end
    else if (load_active)
    begin
      if (hold_cnt == hold_cnt_width'(load_hold_cycles))
        load_active <= 1'b0;
      else
        hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Word assembly
  always_ff @(posedge clk)
  begin
    if (take_byte)
    begin
      if (!high_done)
        load_word[15:8] <= rx_byte;
      else
        load_word[7:0] <= rx_byte;
    end
  end

  // Deposit word holds still for the whole deposit
  a_word_stable_in_deposit: assert property (@(posedge clk) disable iff (clear)
    load_active && $past(load_active) |-> $stable(load_word));

endmodule

/* logic/uart_rx.sv */
// 8N1 receiver sampling each bit at its middle
// Keeps the receive-available flag and sticky framing and overrun errors
`timescale 1ns/1ps

module uart_rx
  import board_io_pkg::*;
(
  input  logic       clk,
  input  logic       clear,
  input  logic       serial_in,
  input  logic       rd_uart_data,
  input  logic       take_byte,
  output logic [7:0] rx_byte,
  output logic       rx_avail,
  output logic       ferr,
  output logic       oerr
);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

  rx_state_t                 state;
  logic [2:0]                rx_sync;
  logic                      rx_bit;
  logic                      rx_fall;
  logic [baud_cnt_width-1:0] baud_cnt;
  logic [2:0]                bit_cnt;
  logic [7:0]                shift;
  logic                      sample_data;
  logic                      byte_taken;

  // Two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
      rx_sync <= '1;
    else
      rx_sync <= {rx_sync[1:0], serial_in};
  end

  assign rx_bit      = rx_sync[1];
  assign rx_fall     = rx_sync[2] && !rx_sync[1];
  assign sample_data = (state == st_data) && (baud_cnt == baud_last);
  assign byte_taken  = rd_uart_data || take_byte;

  // Data bits arrive LSB first
  always_ff @(posedge clk)
  begin
    if (sample_data)
      shift <= {rx_bit, shift[7:1]};
  end

  ////////////////////////////////////////
  // Frame FSM and flags
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
    begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_byte  <= '0;
      rx_avail <= 1'b0;
      ferr     <= 1'b0;
      oerr     <= 1'b0;
    end
    else
    begin
      if (byte_taken)
        rx_avail <= 1'b0;
      case (state)
        st_idle:
        begin
          // Needs a real falling edge, a stuck-low line is ignored
          baud_cnt <= '0;
          if (rx_fall)
            state <= st_start;
        end
        st_start:
        begin
          if (baud_cnt == baud_half)
          begin
            // Glitch shorter than half a bit goes back to idle
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_bit ? st_idle : st_data;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        st_data:
        begin
          if (baud_cnt == baud_last)
          begin
            baud_cnt <= '0;
            if (bit_cnt == 3'd7)
              state <= st_stop;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        st_stop:
        begin
          if (baud_cnt == baud_last)
          begin
            // Middle of stop bit
            state    <= st_idle;
            rx_byte  <= shift;
            rx_avail <= 1'b1;
            if (rx_avail && !byte_taken)
              oerr <= 1'b1;
            if (!rx_bit)
              ferr <= 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* logic/uart_tx.sv */
// 8N1 transmitter with a one-byte holding register
// tbe frees when the stop bit begins, tse once the stop bit has ended
`timescale 1ns/1ps

module uart_tx
  import board_io_pkg::*;
(
  input  logic       clk,
  input  logic       clear,
  input  logic [7:0] bus_wdata,
  input  logic       wr_uart_data,
  output logic       serial_out,
  output logic       tbe,
  output logic       tse
);

  logic                      hold_full;
  logic [7:0]                hold_reg;
  logic                      accept;
  // Bit 0 is the line, idle shifter is all ones
  logic [9:0]                shifter;
  logic                      busy;
  logic [3:0]                bit_cnt;
  logic [baud_cnt_width-1:0] baud_cnt;

  assign accept     = wr_uart_data && !hold_full;
  assign tbe        = !hold_full;
  assign tse        = !busy;
  assign serial_out = shifter[0];

  // Writes while full are dropped
  always_ff @(posedge clk)
  begin
    if (accept)
      hold_reg <= bus_wdata;
  end

  ////////////////////////////////////////
  // Shifter and bit timing
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge clear)
  begin
    if (clear)
    begin
      hold_full <= 1'b0;
      shifter   <= '1;
      busy      <= 1'b0;
      bit_cnt   <= '0;
      baud_cnt  <= '0;
    end
    else
    begin
      if (accept)
        hold_full <= 1'b1;
      if (!busy)
      begin
        if (hold_full)
        begin
          // Stop, data, start
          shifter  <= {1'b1, hold_reg, 1'b0};
          busy     <= 1'b1;
          bit_cnt  <= '0;
          baud_cnt <= '0;
        end
      end
      else if (baud_cnt == baud_last)
      begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd9)
          busy <= 1'b0;
        else
        begin
          shifter <= {1'b1, shifter[9:1]};
          bit_cnt <= bit_cnt + 1'b1;
          // Last data bit done, stop bit on the line
          if (bit_cnt == 4'd8)
            hold_full <= 1'b0;
        end
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (clear)
    tse |-> serial_out);

endmodule

/* logic/io_subsystem.sv */
// Top level of the board I/O section: decode, panel registers, UART and loader
// Deposit word comes from the loader during a serial load, else the switch register
`timescale 1ns/1ps

module io_subsystem
  import board_io_pkg::*;
(
  input  logic                  clk,
  input  logic                  clear,
  input  logic [addr_width-1:0] bus_addr,
  input  logic [data_width-1:0] bus_wdata,
  input  logic                  bus_write,
  input  logic                  bus_read,
  output logic [data_width-1:0] bus_rdata,
  output logic                  mem_ce_n,
  input  logic [7:0]            sw,
  input  logic                  button,
  input  logic                  serial_in,
  output logic                  serial_out,
  output logic [data_width-1:0] deposit_word,
  output logic                  deposit
);

  // Register strobes
  logic                  wr_switch;
  logic                  wr_mode;
  logic                  wr_uart_data;
  logic                  rd_uart_data;

  // Panel state
  logic [data_width-1:0] switch_reg;
  logic                  load_mode_bit;
  logic                  run_bit;
  logic                  load_mode;

  // UART state
  logic [7:0]            rx_byte;
  logic                  rx_avail;
  logic                  ferr;
  logic                  oerr;
  logic                  tbe;
  logic                  tse;

  // Loader
  logic                  take_byte;
  logic [data_width-1:0] load_word;
  logic                  load_active;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////
  io_decode u_decode (
    .clk           (clk),
    .clear         (clear),
    .bus_addr      (bus_addr),
    .bus_write     (bus_write),
    .bus_read      (bus_read),
    .switch_reg    (switch_reg),
    .sw            (sw),
    .button        (button),
    .load_mode_bit (load_mode_bit),
    .run_bit       (run_bit),
    .rx_byte       (rx_byte),
    .rx_avail      (rx_avail),
    .ferr          (ferr),
    .oerr          (oerr),
    .tbe           (tbe),
    .tse           (tse),
    .wr_switch     (wr_switch),
    .wr_mode       (wr_mode),
    .wr_uart_data  (wr_uart_data),
    .rd_uart_data  (rd_uart_data),
    .mem_ce_n      (mem_ce_n),
    .bus_rdata     (bus_rdata)
  );

  panel_regs u_panel (
    .clk           (clk),
    .clear         (clear),
    .bus_wdata     (bus_wdata),
    .wr_switch     (wr_switch),
    .wr_mode       (wr_mode),
    .switch_reg    (switch_reg),
    .load_mode_bit (load_mode_bit),
    .run_bit       (run_bit),
    .load_mode     (load_mode)
  );

  ////////////////////////////////////////
  // Serial side
  ////////////////////////////////////////
  uart_rx u_rx (
    .clk          (clk),
    .clear        (clear),
    .serial_in    (serial_in),
    .rd_uart_data (rd_uart_data),
    .take_byte    (take_byte),
    .rx_byte      (rx_byte),
    .rx_avail     (rx_avail),
    .ferr         (ferr),
    .oerr         (oerr)
  );

  uart_tx u_tx (
    .clk          (clk),
    .clear        (clear),
    .bus_wdata    (bus_wdata[7:0]),
    .wr_uart_data (wr_uart_data),
    .serial_out   (serial_out),
    .tbe          (tbe),
    .tse          (tse)
  );

  serial_loader u_loader (
    .clk         (clk),
    .clear       (clear),
    .load_mode   (load_mode),
    .rx_avail    (rx_avail),
    .rx_byte     (rx_byte),
    .take_byte   (take_byte),
    .load_word   (load_word),
    .load_active (load_active)
  );

  // Deposit source select
  assign deposit_word = load_active ? load_word : switch_reg;
  assign deposit      = load_active;

endmodule

/* sim/io_subsystem_tb.sv */
// Testbench for the board I/O subsystem, replays the operations in sim/io_testdata.txt
// Bus accesses, serial frames and deposit pulses are checked one line at a time
`timescale 1ns/1ps

module io_subsystem_tb
  import board_io_pkg::*;
();

  logic                  clk;
  logic                  clear;
  logic [addr_width-1:0] bus_addr;
  logic [data_width-1:0] bus_wdata;
  logic                  bus_write;
  logic                  bus_read;
  logic [data_width-1:0] bus_rdata;
  logic                  mem_ce_n;
  logic [7:0]            sw;
  logic                  button;
  logic                  serial_in;
  logic                  serial_out;
  logic [data_width-1:0] deposit_word;
  logic                  deposit;

  // Operations from the data file
  logic [7:0]            op_q[$];
  logic [addr_width-1:0] addr_q[$];
  logic [data_width-1:0] value_q[$];
  logic [data_width-1:0] expect_q[$];

  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  // Deposit monitor state
  int                    deposit_pulses = 0;
  int                    deposits_checked = 0;
  int                    deposit_len = 0;
  int                    last_len = 0;
  logic [data_width-1:0] last_word;

  // Serial output monitor state
  int         tx_frames = 0;
  int         tx_checked = 0;
  logic [7:0] tx_byte;
  logic       tx_stop;

  io_subsystem DUT (
    .clk          (clk),
    .clear        (clear),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_write    (bus_write),
    .bus_read     (bus_read),
    .bus_rdata    (bus_rdata),
    .mem_ce_n     (mem_ce_n),
    .sw           (sw),
    .button       (button),
    .serial_in    (serial_in),
    .serial_out   (serial_out),
    .deposit_word (deposit_word),
    .deposit      (deposit)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // Length and word of each deposit pulse
  always @(negedge clk)
  begin
    if (deposit)
    begin
      deposit_len = deposit_len + 1;
      last_word   = deposit_word;
    end
    else if (deposit_len > 0)
    begin
      last_len       = deposit_len;
      deposit_len    = 0;
      deposit_pulses = deposit_pulses + 1;
    end
  end

  // Serial output frames, sampled at bit middles
  always
  begin : tx_monitor
    int bit_idx;
    @(negedge clk);
    if (!clear && !serial_out)
    begin
      repeat (clks_per_bit / 2) @(negedge clk);
      for (bit_idx = 0; bit_idx < 8; bit_idx++)
      begin
        repeat (clks_per_bit) @(negedge clk);
        tx_byte[bit_idx] = serial_out;
      end
      repeat (clks_per_bit) @(negedge clk);
      tx_stop = serial_out;
      // Frame counts once the stop bit is over
      repeat (clks_per_bit / 2) @(negedge clk);
      tx_frames = tx_frames + 1;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_word(input logic [data_width-1:0] got,
                            input logic [data_width-1:0] exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  // Chip enable stays high only inside the I/O block
  function automatic logic expected_ce_n(input logic [addr_width-1:0] a);
    return (a >= 18'h00FF0) && (a <= 18'h00FFF);
  endfunction

  ////////////////////////////////////////
  // Bus and line drivers
  ////////////////////////////////////////
  task automatic write_bus(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
                           output logic ce);
    @(posedge clk);
    bus_addr  <= a;
    bus_wdata <= d;
    bus_write <= 1'b1;
    @(negedge clk);
    ce = mem_ce_n;
    @(posedge clk);
    bus_write <= 1'b0;
  endtask

  task automatic read_bus(input logic [addr_width-1:0] a, output logic [data_width-1:0] d,
                          output logic ce);
    @(posedge clk);
    bus_addr <= a;
    bus_read <= 1'b1;
    @(negedge clk);
    ce = mem_ce_n;
    @(posedge clk);
    bus_read <= 1'b0;
    // Registered read data
    @(negedge clk);
    d = bus_rdata;
  endtask

  task automatic set_panel(input logic [data_width-1:0] v);
    @(posedge clk);
    sw     <= v[7:0];
    button <= v[15];
  endtask

  // 8N1 frame, LSB first
  task automatic send_serial(input logic [7:0] b, input logic stop);
    logic [9:0] frame;
    int         bit_idx;
    frame = {stop, b, 1'b0};
    @(posedge clk);
    for (bit_idx = 0; bit_idx < 10; bit_idx++)
    begin
      serial_in <= frame[bit_idx];
      repeat (clks_per_bit) @(posedge clk);
    end
    serial_in <= 1'b1;
  endtask

  ////////////////////////////////////////
  // Result checks
  ////////////////////////////////////////
  task automatic wait_deposit(input logic expect_pulse, input logic [data_width-1:0] e);
    if (expect_pulse)
    begin
      while (deposit_pulses == deposits_checked)
        @(posedge clk);
      check_word(last_word, e, "deposit_word during deposit");
      check_flag(last_len == load_hold_cycles + 1, 1'b1, "deposit pulse length");
    end
    else
    begin
      @(negedge clk);
      check_flag(deposit, 1'b0, "deposit level");
      check_flag(deposit_pulses != deposits_checked, 1'b0, "unexpected deposit pulse");
      check_word(deposit_word, e, "deposit_word from switch register");
    end
    deposits_checked = deposit_pulses;
  endtask

  task automatic check_tx_frame(input logic [7:0] e);
    while (tx_frames == tx_checked)
      @(posedge clk);
    check_byte(tx_byte, e, "byte on serial_out");
    check_flag(tx_stop, 1'b1, "stop bit on serial_out");
    tx_checked = tx_frames;
  endtask

  // Reads op, address, value and expected value per line
  task automatic load_testdata(output logic ok);
    int                    fd;
    int                    code;
    logic [7:0]            op;
    logic [addr_width-1:0] a;
    logic [data_width-1:0] v;
    logic [data_width-1:0] e;
    logic [8*200-1:0]      rest;
    logic                  done;
    ok = 1'b0;
    fd = $fopen("sim/io_testdata.txt", "r");
    if (fd != 0)
    begin
      ok   = 1'b1;
      done = 1'b0;
      while (!done)
      begin
        code = $fscanf(fd, " %c", op);
        if (code != 1)
          done = 1'b1;
        else if (op == "#")
          code = $fgets(rest, fd);
        else
        begin
          code = $fscanf(fd, " %h %h %h", a, v, e);
          if (code != 3)
          begin
            $display("Malformed line in test data after %0d operations", op_q.size());
            ok   = 1'b0;
            done = 1'b1;
          end
          else
          begin
            op_q.push_back(op);
            addr_q.push_back(a);
            value_q.push_back(v);
            expect_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_op(input int idx);
    logic [7:0]            op;
    logic [addr_width-1:0] a;
    logic [data_width-1:0] v;
    logic [data_width-1:0] e;
    logic [data_width-1:0] data;
    logic                  ce;
    logic                  is_test;
    int                    errors_before;
    op            = op_q[idx];
    a             = addr_q[idx];
    v             = value_q[idx];
    e             = expect_q[idx];
    is_test       = 1'b1;
    errors_before = error_count;
    case (op)
      "W":
      begin
        write_bus(a, v, ce);
        check_flag(ce, e[0], "mem_ce_n during write");
      end
      "R":
      begin
        read_bus(a, data, ce);
        check_word(data, e, "read data");
        check_flag(ce, expected_ce_n(a), "mem_ce_n during read");
      end
      "P":
      begin
        set_panel(v);
        is_test = 1'b0;
      end
      "S":
      begin
        send_serial(v[7:0], e[0]);
        is_test = 1'b0;
      end
      "D": wait_deposit(a[0], e);
      "T": check_tx_frame(e[7:0]);
      default:
      begin
        $display("Unknown operation %c in test data", op);
        error_count++;
      end
    endcase
    if (is_test || error_count != errors_before)
    begin
      if (error_count == errors_before)
        pass_count++;
      else
        fail_count++;
      $display("test %0d: %c addr %h value %h expect %h: %s", idx, op, a, v, e,
               (error_count == errors_before) ? "ok" : "mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial
  begin : main
    logic ok;
    int   idx;
    clear     = 1'b1;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_write = 1'b0;
    bus_read  = 1'b0;
    sw        = '0;
    button    = 1'b0;
    serial_in = 1'b1;
    load_testdata(ok);
    if (!ok)
    begin
      $display("Could not read the test data from sim/io_testdata.txt");
      $display("TESTS FAILED");
      $finish;
    end
    else
    begin
      // Worst case twelve bit times per operation
      cycle_limit = op_q.size() * 12 * clks_per_bit + 1000;
      repeat (8) @(posedge clk);
      clear <= 1'b0;
      for (idx = 0; idx < op_q.size(); idx++)
        run_op(idx);
      repeat (4) @(posedge clk);
      $display("tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
               pass_count, fail_count);
      if (fail_count == 0 && error_count == 0 && pass_count > 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

/* sim/io_testdata.txt */
# op addr value expect, all hex; W expect = mem_ce_n, R expect = read data, P value = inputs
# S value = byte, expect = stop bit; D addr 1 waits for a deposit, 0 expects none; T expect = byte
W 00FF0 1234 1
R 00FF0 0000 1234
W 00FF2 FFFF 1
R 00FF2 0000 0003
P 00000 80A5 0
R 00FF1 0000 80A5
W 01234 BEEF 0
R 3FFFF 0000 0000
W 00FF2 0001 1
S 00000 0012 1
S 00000 0034 1
D 00001 0000 1234
W 00FF0 A5A5 1
W 00FF2 0003 1
S 00000 0055 1
D 00000 0000 A5A5
R 00FFE 0000 C800
R 00FFF 0000 8055
R 00FFE 0000 C000
W 00FF2 0000 1
W 00FFF 005A 1
R 00FFE 0000 0000
T 00000 0000 005A
R 00FFE 0000 C000
S 00000 0011 1
S 00000 0022 1
R 00FFE 0000 D800
R 00FFF 0000 8022
S 00000 0033 0
R 00FFE 0000 F800
R 00FFF 0000 8033
R 00FFE 0000 F000

/* flist.f */
logic/board_io_pkg.sv
logic/io_decode.sv
logic/panel_regs.sv
logic/serial_loader.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/io_subsystem.sv
sim/io_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the I/O subsystem testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module io_subsystem_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vio_subsystem_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
